// ==== compile.f ====
logic/serial_pkg.sv
logic/key_debounce.sv
logic/message_sequencer.sv
logic/uart_tx.sv
logic/status_leds.sv
logic/serial_message_top.sv
verification/tb_serial_message.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
# a failing check ends in $fatal, so the exit status is non-zero
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_serial_message \
	-f compile.f \
	-o tb_serial_message

./obj_dir/tb_serial_message

// ==== verification/tb_serial_message.sv ====
// drives both keys through press, select, bounce and re-press; checks are immediate assertions
`timescale 1ns/1ps

module tb_serial_message;

	// serial timing at 27 MHz and 115200 baud
	localparam int bit_len = 234;
	localparam int half_bit = bit_len / 2;
	localparam int frame_len = 10 * bit_len;
	// key timing
	localparam int hold_cycles = 40_000;
	localparam int settle_cycles = 70_000;
	// six presses at about 110000 cycles each, with a wide margin
	localparam int timeout_cycles = 2_000_000;

	logic clk27;
	logic rst;
	logic [1:0] key;
	logic serial_tx;
	logic [5:0] led;

	// decoded characters of the current message
	logic [7:0] rx_chars [$];
	int fall_cnt = 0;
	int cycle_cnt = 0;
	int falls_before;
	bit first_press = 1'b0;

	serial_message_top uut (
		.clk27    (clk27),
		.rst      (rst),
		.key      (key),
		.serial_tx(serial_tx),
		.led      (led)
	);

	initial begin
		clk27 = 1'b0;
		forever #4 clk27 = ~clk27;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic report_mismatch(input string test_name, input int expected, input int actual);
		$display("MISMATCH %s expected %0h actual %0h", test_name, expected, actual);
		$display("Result: FAILED");
		$fatal(1, "check %s failed", test_name);
	endtask

	// hold low, release, then let the release debounce
	task press_key(input int idx);
		@(posedge clk27);
		key[idx] <= 1'b0;
		repeat (hold_cycles) @(posedge clk27);
		key[idx] <= 1'b1;
		repeat (settle_cycles) @(posedge clk27);
	endtask

	task automatic wait_message_done();
		while (rx_chars.size() < 4 || led[2] == 1'b0)
			@(negedge clk27);
	endtask

	task automatic check_message(input string test_name, input string expected);
		@(negedge clk27);
		assert (rx_chars.size() == expected.len())
			else report_mismatch(test_name, expected.len(), rx_chars.size());
		for (int i = 0; i < expected.len(); i++) begin
			assert (rx_chars[i] == expected[i])
				else report_mismatch(test_name, int'(expected[i]), int'(rx_chars[i]));
		end
	endtask

	// count leds are lit low
	task automatic check_count(input string test_name, input int n);
		@(negedge clk27);
		assert (led[5:3] == ~3'(n))
			else report_mismatch(test_name, int'(~3'(n)), int'(led[5:3]));
	endtask

	// ------------------------------------------------------------------------
	// monitors
	// ------------------------------------------------------------------------
	always @(posedge clk27) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("timeout: run went past %0d cycles", timeout_cycles);
			$display("Result: FAILED");
			$fatal(1, "timeout");
		end
	end

	// quiet line and dark leds until the first press
	always @(negedge clk27) begin
		if (!rst && !first_press) begin
			assert (serial_tx === 1'b1) else report_mismatch("idle_line", 1, int'(serial_tx));
			assert (led === 6'h3f) else report_mismatch("idle_leds", 'h3f, int'(led));
		end
	end

	// 8N1 decoder, samples mid bit on the falling clock
	initial begin : frame_decoder
		logic [9:0] frame;
		int stamp;
		int prev_stamp;
		prev_stamp = 0;
		forever begin
			@(negedge serial_tx);
			// first low phase of the start bit
			@(negedge clk27);
			stamp = cycle_cnt;
			fall_cnt++;
			// back to back frames inside one message
			if (rx_chars.size() > 0) begin
				assert (stamp - prev_stamp == frame_len + 1)
					else report_mismatch("frame_spacing", frame_len + 1, stamp - prev_stamp);
			end
			prev_stamp = stamp;
			repeat (half_bit) @(negedge clk27);
			for (int k = 0; k < 10; k++) begin
				if (k > 0)
					repeat (bit_len) @(negedge clk27);
				frame[k] = serial_tx;
				assert (led[1] == 1'b0) else report_mismatch("busy_led", 0, int'(led[1]));
				assert (led[2] == 1'b0) else report_mismatch("active_led", 0, int'(led[2]));
			end
			assert (frame[0] == 1'b0) else report_mismatch("start_bit", 0, int'(frame[0]));
			assert (frame[9] == 1'b1) else report_mismatch("stop_bit", 1, int'(frame[9]));
			rx_chars.push_back(frame[8:1]);
			// the one idle cycle after the stop bit
			repeat (frame_len - half_bit - 9 * bit_len) @(negedge clk27);
			assert (serial_tx == 1'b1) else report_mismatch("gap_line", 1, int'(serial_tx));
			assert (led[1] == 1'b1) else report_mismatch("gap_busy_led", 1, int'(led[1]));
		end
	end

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(51));
		key <= 2'b11;
		rst <= 1'b1;
		repeat (8) @(posedge clk27);
		rst <= 1'b0;
		repeat (1000) @(posedge clk27);

		// first message
		first_press = 1'b1;
		rx_chars.delete();
		press_key(0);
		wait_message_done();
		check_message("send_test", "Test");
		check_count("count_after_test", 1);

		// switch to the second message
		press_key(1);
		@(negedge clk27);
		assert (led[0] == 1'b0) else report_mismatch("select_led", 0, int'(led[0]));
		rx_chars.delete();
		press_key(0);
		wait_message_done();
		check_message("send_good", "Good");
		check_count("count_after_good", 2);

		// short bounces, all under the debounce window
		falls_before = fall_cnt;
		for (int i = 0; i < 8; i++) begin
			@(posedge clk27);
			key[0] <= 1'b0;
			repeat (int'($urandom_range(30_000, 1))) @(posedge clk27);
			key[0] <= 1'b1;
			repeat (int'($urandom_range(500, 1))) @(posedge clk27);
		end
		repeat (hold_cycles) @(posedge clk27);
		@(negedge clk27);
		assert (fall_cnt == falls_before)
			else report_mismatch("bounce_edges", falls_before, fall_cnt);
		check_count("count_after_bounce", 2);

		// re-press while the message is on the line
		rx_chars.delete();
		falls_before = fall_cnt;
		@(posedge clk27);
		key[0] <= 1'b0;
		while (fall_cnt == falls_before)
			@(posedge clk27);
		key[0] <= 1'b1;
		repeat (100) @(posedge clk27);
		key[0] <= 1'b0;
		repeat (hold_cycles) @(posedge clk27);
		key[0] <= 1'b1;
		repeat (settle_cycles) @(posedge clk27);
		wait_message_done();
		check_message("repress_ignored", "Good");
		check_count("count_after_repress", 3);

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== logic/serial_message_top.sv ====
// 27 MHz board, active-low keys and leds; serial line is 115200 baud 8N1, transmit only
`timescale 1ns/1ps

module serial_message_top (
	input  logic clk27,
	input  logic rst,
	input  logic [1:0] key,
	output logic serial_tx,
	output logic [5:0] led
);

	// ------------------------------------------------------------------------
	// interconnect
	// ------------------------------------------------------------------------
	serial_pkg::key_event_t send_ev;
	serial_pkg::key_event_t select_ev;
	serial_pkg::tx_cmd_t tx_cmd;
	serial_pkg::tx_status_t tx_status;
	serial_pkg::seq_status_t seq_status;
	// waveform only, not on a port
	logic [1:0] byte_index;

	// key 0 sends, key 1 picks the message
	key_debounce u_keys (
		.clk27 (clk27),
		.rst   (rst),
		.key   (key),
		.send  (send_ev),
		.select(select_ev)
	);

	message_sequencer u_seq (
		.clk27     (clk27),
		.rst       (rst),
		.send      (send_ev),
		.select    (select_ev),
		.tx_status (tx_status),
		.tx_cmd    (tx_cmd),
		.status    (seq_status),
		.byte_index(byte_index)
	);

	uart_tx u_tx (
		.clk27    (clk27),
		.rst      (rst),
		.cmd      (tx_cmd),
		.status   (tx_status),
		.serial_tx(serial_tx)
	);

	status_leds u_leds (
		.clk27(clk27),
		.rst  (rst),
		.seq  (seq_status),
		.tx   (tx_status),
		.led  (led)
	);

endmodule

// ==== logic/status_leds.sv ====
// leds are active low; the completed-message count wraps after 7
`timescale 1ns/1ps

module status_leds (
	input  logic clk27,
	input  logic rst,
	input  serial_pkg::seq_status_t seq,
	input  serial_pkg::tx_status_t tx,
	output logic [5:0] led
);

	// messages finished, modulo 8
	logic [2:0] done_cnt;

	// ------------------------------------------------------------------------
	// completion counter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			done_cnt <= '0;
		end else if (seq.msg_done) begin
			done_cnt <= done_cnt + 3'd1;
		end
	end

	// ------------------------------------------------------------------------
	// led drive
	// ------------------------------------------------------------------------
	// 0 selected message
	// 1 transmitter busy
	// 2 message in progress
	// 5:3 completed count
	// all lit when low
	assign led = ~{done_cnt, seq.active, tx.busy, seq.sel};

endmodule

// ==== logic/uart_tx.sv ====
// 8N1 frames, lsb first; a start pulse while busy is ignored
`timescale 1ns/1ps

module uart_tx (
	input  logic clk27,
	input  logic rst,
	input  serial_pkg::tx_cmd_t cmd,
	output serial_pkg::tx_status_t status,
	output logic serial_tx
);

	// stop, data, start; bit 0 drives the line
	logic [serial_pkg::frame_bits-1:0] shift_q;
	logic [serial_pkg::baud_cnt_w-1:0] baud_cnt;
	logic [serial_pkg::bit_cnt_w-1:0] bit_cnt;
	logic busy;
	logic byte_done;
	logic bit_end;

	// last cycle of the current bit
	assign bit_end = (baud_cnt == serial_pkg::baud_last);

	// ------------------------------------------------------------------------
	// frame shifter
	// ------------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			// line idles high
			shift_q <= '1;
			baud_cnt <= '0;
			bit_cnt <= '0;
			busy <= 1'b0;
			byte_done <= 1'b0;
		end else begin
			byte_done <= 1'b0;
			if (!busy) begin
				if (cmd.start) begin
					shift_q <= {1'b1, cmd.data, 1'b0};
					baud_cnt <= '0;
					bit_cnt <= '0;
					busy <= 1'b1;
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				// fill with ones so the line returns to idle
				shift_q <= {1'b1, shift_q[serial_pkg::frame_bits-1:1]};
				if (bit_cnt == serial_pkg::bit_last) begin
					// stop bit finished
					bit_cnt <= '0;
					busy <= 1'b0;
					byte_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------------
	// straight from a flop, no glitches on the line
	assign serial_tx = shift_q[0];
	assign status = '{busy: busy, byte_done: byte_done};

endmodule

// ==== logic/message_sequencer.sv ====
// presses during a message are dropped; a new selection applies from the next message
`timescale 1ns/1ps

module message_sequencer (
	input  logic clk27,
	input  logic rst,
	input  serial_pkg::key_event_t send,
	input  serial_pkg::key_event_t select,
	input  serial_pkg::tx_status_t tx_status,
	output serial_pkg::tx_cmd_t tx_cmd,
	output serial_pkg::seq_status_t status,
	output logic [1:0] byte_index
);

	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_wait_done
	} seq_state_t;

	seq_state_t state;
	// message latched at the send press
	logic sel_q;
	// character currently on the line
	logic [1:0] byte_idx;
	logic msg_done;
	logic last_byte;
	logic [1:0] char_idx;
	logic start;

	assign last_byte = (byte_idx == 2'(serial_pkg::msg_len - 1));

	// load sends the current character
	// wait_done already offers the following one
	assign char_idx = (state == st_load) ? byte_idx : byte_idx + 2'd1;

	// ------------------------------------------------------------------------
	// start generation
	// ------------------------------------------------------------------------
	always_comb begin
		start = 1'b0;
		case (state)
			st_load: start = ~tx_status.busy;
			// back to back with the finished frame, one idle cycle on the line
			st_wait_done: start = tx_status.byte_done & ~last_byte;
			default: start = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------------
	// state register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			state <= st_idle;
			sel_q <= 1'b0;
			byte_idx <= '0;
			msg_done <= 1'b0;
		end else begin
			msg_done <= 1'b0;
			case (state)
				st_idle: begin
					if (send.press) begin
						sel_q <= select.toggle;
						byte_idx <= '0;
						state <= st_load;
					end
				end
				st_load: begin
					// wait for the transmitter to accept character 0
					if (!tx_status.busy)
						state <= st_wait_done;
				end
				st_wait_done: begin
					if (tx_status.byte_done) begin
						if (last_byte) begin
							msg_done <= 1'b1;
							state <= st_idle;
						end else begin
							byte_idx <= byte_idx + 2'd1;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign tx_cmd = '{start: start, data: serial_pkg::messages[sel_q][char_idx]};
	// led shows the live selection, not the latched one
	assign status = '{active: (state != st_idle), msg_done: msg_done, sel: select.toggle};
	assign byte_index = byte_idx;

endmodule

// ==== logic/key_debounce.sv ====
// keys are active low and idle high; a level is accepted after 32768 stable cycles
`timescale 1ns/1ps

module key_debounce (
	input  logic clk27,
	input  logic rst,
	input  logic [1:0] key,
	output serial_pkg::key_event_t send,
	output serial_pkg::key_event_t select
);

	// two-flop synchronizer, keys inverted so 1 means pressed
	logic [1:0] sync_a;
	logic [1:0] sync_b;

	// one stability counter and one event record per key
	logic [serial_pkg::debounce_cnt_w-1:0] stable_cnt [2];
	serial_pkg::key_event_t ev [2];

	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			sync_a <= '0;
			sync_b <= '0;
		end else begin
			sync_a <= ~key;
			sync_b <= sync_a;
		end
	end

	// ------------------------------------------------------------------------
	// stability counters
	// ------------------------------------------------------------------------
	always_ff @(posedge clk27, posedge rst) begin
		if (rst) begin
			for (int k = 0; k < 2; k++) begin
				stable_cnt[k] <= '0;
				ev[k] <= '0;
			end
		end else begin
			for (int k = 0; k < 2; k++) begin
				// press is a single-cycle pulse
				ev[k].press <= 1'b0;
				if (sync_b[k] == ev[k].level) begin
					// input agrees with accepted level, restart window
					stable_cnt[k] <= '0;
				end else if (stable_cnt[k] == serial_pkg::debounce_last) begin
					stable_cnt[k] <= '0;
					ev[k].level <= sync_b[k];
					// rising level only
					if (sync_b[k]) begin
						ev[k].press <= 1'b1;
						ev[k].toggle <= ~ev[k].toggle;
					end
				end else begin
					stable_cnt[k] <= stable_cnt[k] + 1'b1;
				end
			end
		end
	end

	// key 0 sends, key 1 selects
	assign send = ev[0];
	assign select = ev[1];

endmodule

// ==== logic/serial_pkg.sv ====
// 27 MHz clock assumed; the baud divider truncates to 234 cycles, about 0.16 percent fast
package serial_pkg;

	// ------------------------------------------------------------------------
	// timing
	// ------------------------------------------------------------------------
	localparam logic [31:0] main_clk_hz = 32'd27_000_000;
	localparam logic [31:0] serial_clk_hz = 32'd115_200;
	// integer division drops the fraction of 234.375
	localparam logic [31:0] bit_cycles = main_clk_hz / serial_clk_hz;
	localparam logic [31:0] debounce_cycles = 32'd32_768;

	// counter widths and terminal counts
	localparam int baud_cnt_w = $clog2(bit_cycles);
	localparam logic [baud_cnt_w-1:0] baud_last = baud_cnt_w'(bit_cycles - 1);
	localparam int debounce_cnt_w = $clog2(debounce_cycles);
	localparam logic [debounce_cnt_w-1:0] debounce_last = debounce_cnt_w'(debounce_cycles - 1);

	// ------------------------------------------------------------------------
	// frame and message
	// ------------------------------------------------------------------------
	localparam int data_bits = 8;
	// start bit, data, stop bit
	localparam int frame_bits = data_bits + 2;
	localparam int bit_cnt_w = $clog2(frame_bits);
	localparam logic [bit_cnt_w-1:0] bit_last = bit_cnt_w'(frame_bits - 1);

	localparam int msg_len = 4;
	// leftmost character goes out first
	localparam logic [0:1][0:msg_len-1][data_bits-1:0] messages = {"Test", "Good"};

	// ------------------------------------------------------------------------
	// shared structs
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic level;
		logic press;
		logic toggle;
	} key_event_t;

	typedef struct packed {
		logic start;
		logic [data_bits-1:0] data;
	} tx_cmd_t;

	typedef struct packed {
		logic busy;
		logic byte_done;
	} tx_status_t;

	typedef struct packed {
		logic active;
		logic msg_done;
		logic sel;
	} seq_status_t;

endpackage
